// File: flist.f
+incdir+verilog
verilog/nkmd_pkg.sv
verilog/nkmd_fetch.sv
verilog/nkmd_seq.sv
verilog/nkmd_decode.sv
verilog/nkmd_regfile.sv
verilog/nkmd_mem_stage.sv
verilog/nkmd_alu.sv
verilog/nkmd_cpu.sv
sim/nkmd_cpu_tb.sv

// File: sim/nkmd_cpu_tb.sv
`timescale 1ns/1ps
`include "nkmd_config.svh"

module nkmd_cpu_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int GAP_NOPS      = 4;
    localparam int REPEAT_ISSUES = 3;

    localparam logic [3:0] REG_A = 4'h1;
    localparam logic [3:0] REG_B = 4'h2;
    localparam logic [3:0] REG_C = 4'h3;
    localparam logic [3:0] REG_D = 4'h4;
    localparam logic [3:0] REG_E = 4'h5;

    // Random sums go to i, j, sl, sh, b and c
    localparam logic [23:0] RND_DST = {4'h3, 4'h2, 4'hd, 4'hc, 4'ha, 4'h9};

    typedef struct packed {
        logic        bus_c;
        logic [31:0] addr;
    } strobe_t;

    // One instruction and the strobes it must produce
    typedef struct packed {
        logic [31:0] word;
        logic [2:0]  count;
        logic        bus_c;
        logic [31:0] addr;
    } step_t;

    logic        clk;
    logic        rst;
    logic [31:0] p_data_i;
    logic [31:0] r_data_i;
    logic [31:0] c_data_i;
    logic [31:0] p_addr_o;
    logic [31:0] r_addr_o;
    logic        r_re_o;
    logic [31:0] c_addr_o;
    logic        c_re_o;

    logic [31:0] prog [$];
    step_t       steps [$];
    strobe_t     expected [$];
    int          seen;
    integer      seed;

    nkmd_cpu UUT (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data_i),
        .r_data_i (r_data_i),
        .c_data_i (c_data_i),
        .p_addr_o (p_addr_o),
        .r_addr_o (r_addr_o),
        .r_re_o   (r_re_o),
        .c_addr_o (c_addr_o),
        .c_re_o   (c_re_o)
    );

    function automatic logic [31:0] imm_word(input logic [3:0] rd, input logic [2:0] op,
                                             input logic [3:0] rs, input logic [15:0] imm);
        return {4'h0, rd, op, rs, 1'b1, imm};
    endfunction

    function automatic logic [31:0] reg_word(input logic [3:0] rd, input logic [2:0] op,
                                             input logic [3:0] rs, input logic [3:0] rt,
                                             input logic repn, input logic r_rd,
                                             input logic c_rd);
        return {4'h0, rd, op, rs, 1'b0, 3'b000, repn, rt, 6'b000000, r_rd, c_rd};
    endfunction

    function automatic logic [31:0] program_word(input logic [31:0] addr);
        logic [31:0] word;
        if (addr < prog.size()) begin
            word = prog[addr];
        end else begin
            word = '0;
        end
        return word;
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (got !== want) begin
            $display("error at %0d ns: %s expected %h, actual %h", $time, name, want, got);
            stop_run();
        end
    endtask

    task automatic add_step(input logic [31:0] word, input int count, input logic bus_c,
                            input logic [31:0] addr);
        step_t s;
        s.word  = word;
        s.count = count[2:0];
        s.bus_c = bus_c;
        s.addr  = addr;
        steps.push_back(s);
    endtask

    // R read of one register into c0
    task automatic add_probe(input logic [3:0] rs, input logic [31:0] value);
        add_step(reg_word(`NKMD_REG_C0, `NKMD_OP_ADD, rs, `NKMD_REG_C0, 1'b0, 1'b1, 1'b0),
                 1, 1'b0, value);
    endtask

    task automatic build_steps();
        logic [31:0] rnd;
        logic [15:0] imm;
        logic [3:0]  dst;
        add_step(imm_word(REG_A, `NKMD_OP_ADD, `NKMD_REG_C0, 16'h1234), 0, 1'b0, '0);
        add_step(imm_word(REG_B, `NKMD_OP_ADD, `NKMD_REG_C0, 16'hf0f0), 0, 1'b0, '0);
        // Codes 0 to 5 on a and b into c..h
        for (int k = 0; k < 6; k++) begin
            dst = REG_C + k[3:0];
            add_step(reg_word(dst, k[2:0], REG_A, REG_B, 1'b0, 1'b0, 1'b0), 0, 1'b0, '0);
        end
        add_probe(4'h3, 32'h0000_0324);
        add_probe(4'h4, 32'h0000_2144);
        add_probe(4'h5, 32'hffff_f2f4);
        add_probe(4'h6, 32'h0000_1030);
        add_probe(4'h7, 32'hffff_e2c4);
        add_probe(4'h8, 32'h0000_0000);
        // Bus operands and then a write to c0
        add_step(reg_word(REG_D, `NKMD_OP_ADD, REG_A, `NKMD_REG_C0, 1'b0, 1'b1, 1'b0),
                 1, 1'b0, 32'h0000_1234);
        add_step(reg_word(REG_E, `NKMD_OP_ADD, `NKMD_REG_C0, REG_B, 1'b0, 1'b0, 1'b1),
                 1, 1'b1, 32'hffff_f0f0);
        add_step(imm_word(`NKMD_REG_C0, `NKMD_OP_ADD, `NKMD_REG_C0, 16'h5555), 0, 1'b0, '0);
        add_probe(REG_D, 32'h0000_1334);
        add_probe(REG_E, 32'hffff_f00f);
        add_probe(`NKMD_REG_C0, 32'h0);
        // n = 3 gives four issues of the repeat read
        add_step(imm_word(`NKMD_REG_N, `NKMD_OP_ADD, `NKMD_REG_C0, 16'd3), 0, 1'b0, '0);
        add_step(reg_word(`NKMD_REG_C0, `NKMD_OP_ADD, REG_A, `NKMD_REG_C0, 1'b1, 1'b1, 1'b0),
                 REPEAT_ISSUES + 1, 1'b0, 32'h0000_1234);
        add_probe(`NKMD_REG_N, 32'h0);
        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            imm = rnd[15:0];
            dst = RND_DST[4*k +: 4];
            add_step(imm_word(dst, `NKMD_OP_ADD, REG_A, imm), 0, 1'b0, '0);
            add_probe(dst, 32'h0000_1234 + {{16{imm[15]}}, imm});
        end
    endtask

    task automatic fill_program();
        foreach (steps[i]) begin
            prog.push_back(steps[i].word);
            for (int k = 0; k < GAP_NOPS; k++) begin
                prog.push_back('0);
            end
            for (int k = 0; k < steps[i].count; k++) begin
                expected.push_back({steps[i].bus_c, steps[i].addr});
            end
        end
    endtask

    task automatic match_strobe(input logic bus_c, input logic [31:0] addr);
        strobe_t want;
        if (seen >= expected.size()) begin
            $display("error at %0d ns: a strobe on the %s bus came after the last expected one",
                     $time, bus_c ? "C" : "R");
            stop_run();
        end else begin
            want = expected[seen];
            check_value(bus_c ? "c_re_o" : "r_re_o", 32'(want.bus_c == bus_c), 32'd1);
            check_value(bus_c ? "c_addr_o" : "r_addr_o", want.addr, addr);
            seen++;
        end
    endtask

    task automatic watchdog();
        int budget;
        budget = (prog.size() + REPEAT_ISSUES + 20) * CLK_PERIOD;
        #(budget);
        $display("error at %0d ns: timeout with %0d of %0d strobes seen",
                 $time, seen, expected.size());
        stop_run();
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Bus models with one cycle of read latency
    always @(posedge clk) begin
        p_data_i <= program_word(p_addr_o);
        r_data_i <= r_addr_o + 32'h100;
        c_data_i <= c_addr_o ^ 32'hff;
    end

    always @(negedge clk) begin
        if (r_re_o === 1'b1) begin
            match_strobe(1'b0, r_addr_o);
        end
        if (c_re_o === 1'b1) begin
            match_strobe(1'b1, c_addr_o);
        end
    end

    initial begin
        rst      = 1'b1;
        p_data_i = '0;
        r_data_i = '0;
        c_data_i = '0;
        seed     = 32'h4a97784a;
        seen     = 0;
        build_steps();
        fill_program();
        fork
            watchdog();
        join_none
        // Last check falls in the cycle after reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_value("p_addr_o", '0, p_addr_o);
            check_value("r_re_o", '0, 32'(r_re_o));
            check_value("c_re_o", '0, 32'(c_re_o));
        end
        while (seen < expected.size()) begin
            @(negedge clk);
        end
        while (p_addr_o < prog.size() + 4) begin
            @(negedge clk);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verilog/nkmd_alu.sv
`timescale 1ns/1ps
`include "nkmd_config.svh"

module nkmd_alu (
    input  logic                    clk,
    input  logic                    rst,
    input  nkmd_pkg::exec_t         exec_i,
    input  logic [`NKMD_WORD_W-1:0] r_data_i,
    input  logic [`NKMD_WORD_W-1:0] c_data_i,
    output nkmd_pkg::wb_t           wb_o
);
    import nkmd_pkg::*;

    logic [`NKMD_WORD_W-1:0] s_val;
    logic [`NKMD_WORD_W-1:0] t_val;
    logic [`NKMD_WORD_W-1:0] result;
    wb_t                     wb_q;

    always_comb begin
        s_val = exec_i.r_read_en ? r_data_i : exec_i.rs_val;
        if (exec_i.imm_en) begin
            t_val = exec_i.imm;
        end else if (exec_i.c_read_en) begin
            t_val = c_data_i;
        end else begin
            t_val = exec_i.rt_val;
        end
    end

    always_comb begin
        case (exec_i.alu_op)
            `NKMD_OP_ADD: result = s_val + t_val;
            `NKMD_OP_SUB: result = s_val - t_val;
            `NKMD_OP_OR:  result = s_val | t_val;
            `NKMD_OP_AND: result = s_val & t_val;
            `NKMD_OP_XOR: result = s_val ^ t_val;
            // clamp and mul not implemented
            `NKMD_OP_RESERVED, `NKMD_OP_CLAMP, `NKMD_OP_MUL: result = '0;
            default: result = '0;
        endcase
    end

    // c0 as target means no write
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q <= '0;
        end else begin
            wb_q.sel <= exec_i.rd_sel;
            wb_q.val <= result;
        end
    end

    assign wb_o = wb_q;

endmodule

// File: verilog/nkmd_config.svh
`ifndef NKMD_CONFIG_SVH
`define NKMD_CONFIG_SVH

`define NKMD_WORD_W   32
`define NKMD_REGSEL_W 4
`define NKMD_ALUSEL_W 3
`define NKMD_IMM_W    16

// Register slots with special meaning
`define NKMD_REG_C0 4'h0
`define NKMD_REG_RA 4'hb
`define NKMD_REG_N  4'he
`define NKMD_REG_PC 4'hf

`define NKMD_OP_ADD      3'h0
`define NKMD_OP_SUB      3'h1
`define NKMD_OP_OR       3'h2
`define NKMD_OP_AND      3'h3
`define NKMD_OP_XOR      3'h4
`define NKMD_OP_RESERVED 3'h5
`define NKMD_OP_CLAMP    3'h6
`define NKMD_OP_MUL      3'h7

`endif

// File: verilog/nkmd_cpu.sv
`timescale 1ns/1ps
`include "nkmd_config.svh"

module nkmd_cpu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`NKMD_WORD_W-1:0] p_data_i,
    input  logic [`NKMD_WORD_W-1:0] r_data_i,
    input  logic [`NKMD_WORD_W-1:0] c_data_i,
    output logic [`NKMD_WORD_W-1:0] p_addr_o,
    output logic [`NKMD_WORD_W-1:0] r_addr_o,
    output logic                    r_re_o,
    output logic [`NKMD_WORD_W-1:0] c_addr_o,
    output logic                    c_re_o
);
    import nkmd_pkg::*;

    inst_t fetch_inst;
    dcd_t  dcd;
    exec_t rf_exec;
    exec_t mem_exec;
    wb_t   alu_wb;
    logic  dcd_repn;
    logic  n_is_zero;
    logic  stall;
    logic  dec_n;
    logic  use_hold;
    logic  inst_valid;

    nkmd_fetch u_fetch (
        .clk          (clk),
        .rst          (rst),
        .p_data_i     (p_data_i),
        .stall_i      (stall),
        .use_hold_i   (use_hold),
        .inst_valid_i (inst_valid),
        .p_addr_o     (p_addr_o),
        .inst_o       (fetch_inst)
    );

    nkmd_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .repn_i       (dcd_repn),
        .n_is_zero_i  (n_is_zero),
        .stall_o      (stall),
        .dec_n_o      (dec_n),
        .use_hold_o   (use_hold),
        .inst_valid_o (inst_valid)
    );

    nkmd_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .inst_i  (fetch_inst),
        .stall_i (stall),
        .dcd_o   (dcd),
        .repn_o  (dcd_repn)
    );

    nkmd_regfile u_regfile (
        .clk         (clk),
        .rst         (rst),
        .dcd_i       (dcd),
        .dec_n_i     (dec_n),
        .wb_i        (alu_wb),
        .exec_o      (rf_exec),
        .n_is_zero_o (n_is_zero)
    );

    nkmd_mem_stage u_mem_stage (
        .clk      (clk),
        .rst      (rst),
        .exec_i   (rf_exec),
        .r_addr_o (r_addr_o),
        .r_re_o   (r_re_o),
        .c_addr_o (c_addr_o),
        .c_re_o   (c_re_o),
        .exec_o   (mem_exec)
    );

    nkmd_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .exec_i   (mem_exec),
        .r_data_i (r_data_i),
        .c_data_i (c_data_i),
        .wb_o     (alu_wb)
    );

endmodule

// File: verilog/nkmd_decode.sv
`timescale 1ns/1ps
`include "nkmd_config.svh"

module nkmd_decode (
    input  logic            clk,
    input  logic            rst,
    input  nkmd_pkg::inst_t inst_i,
    input  logic            stall_i,
    output nkmd_pkg::dcd_t  dcd_o,
    output logic            repn_o
);
    import nkmd_pkg::*;

    dcd_t dcd_d;
    dcd_t dcd_q;

    always_comb begin
        dcd_d.rd_sel = inst_i.rd_sel;
        dcd_d.rs_sel = inst_i.rs_sel;
        dcd_d.alu_op = inst_i.alu_op;
        dcd_d.imm_en = inst_i.imm_en;
        if (inst_i.imm_en) begin
            dcd_d.imm = {{(`NKMD_WORD_W-`NKMD_IMM_W){inst_i.low.imm_view[`NKMD_IMM_W-1]}},
                         inst_i.low.imm_view};
            dcd_d.rt_sel    = `NKMD_REG_C0;
            dcd_d.r_read_en = 1'b0;
            dcd_d.c_read_en = 1'b0;
            dcd_d.repn      = 1'b0;
        end else begin
            dcd_d.imm       = '0;
            dcd_d.rt_sel    = inst_i.low.reg_view.rt_sel;
            dcd_d.r_read_en = inst_i.low.reg_view.r_rd;
            dcd_d.c_read_en = inst_i.low.reg_view.c_rd;
            dcd_d.repn      = inst_i.low.reg_view.repn;
        end
    end

    // All-zero word decodes as the NOP
    always_ff @(posedge clk) begin
        if (rst) begin
            dcd_q <= '0;
        end else if (!stall_i) begin
            dcd_q <= dcd_d;
        end
    end

    assign dcd_o  = dcd_q;
    assign repn_o = dcd_q.repn;

endmodule

// File: verilog/nkmd_fetch.sv
`timescale 1ns/1ps
`include "nkmd_config.svh"

module nkmd_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`NKMD_WORD_W-1:0] p_data_i,
    input  logic                    stall_i,
    input  logic                    use_hold_i,
    input  logic                    inst_valid_i,
    output logic [`NKMD_WORD_W-1:0] p_addr_o,
    output nkmd_pkg::inst_t         inst_o
);
    import nkmd_pkg::*;

    logic [`NKMD_WORD_W-1:0] pc_q;
    inst_t                   hold_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (!stall_i) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    // Keep the word in flight on the first stall cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_q <= '0;
        end else if (stall_i && !use_hold_i) begin
            hold_q <= inst_t'(p_data_i);
        end
    end

    always_comb begin
        if (!inst_valid_i) begin
            inst_o = '0;
        end else if (use_hold_i) begin
            inst_o = hold_q;
        end else begin
            inst_o = inst_t'(p_data_i);
        end
    end

    assign p_addr_o = pc_q;

    // Word in flight is replayed once the stall begins
    a_replay_word: assert property (@(posedge clk) disable iff (rst)
        stall_i && !use_hold_i |=> inst_o == $past(p_data_i))
        else $error("fetch: word in flight lost across a stall");

endmodule

// File: verilog/nkmd_mem_stage.sv
`timescale 1ns/1ps
`include "nkmd_config.svh"

module nkmd_mem_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  nkmd_pkg::exec_t         exec_i,
    output logic [`NKMD_WORD_W-1:0] r_addr_o,
    output logic                    r_re_o,
    output logic [`NKMD_WORD_W-1:0] c_addr_o,
    output logic                    c_re_o,
    output nkmd_pkg::exec_t         exec_o
);
    import nkmd_pkg::*;

    exec_t exec_q;

    // Registers hold the bus addresses
    assign r_addr_o = exec_i.rs_val;
    assign c_addr_o = exec_i.rt_val;
    assign r_re_o   = exec_i.r_read_en;
    assign c_re_o   = exec_i.c_read_en;

    // Bus data returns one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_q <= '0;
        end else begin
            exec_q <= exec_i;
        end
    end

    assign exec_o = exec_q;

endmodule

// File: verilog/nkmd_pkg.sv
`include "nkmd_config.svh"

package nkmd_pkg;

    // Low half of a register-form instruction
    typedef struct packed {
        logic [2:0]                spare_hi;
        logic                      repn;
        logic [`NKMD_REGSEL_W-1:0] rt_sel;
        logic [5:0]                spare_lo;
        logic                      r_rd;
        logic                      c_rd;
    } inst_reg_view_t;

    // imm_en picks the view
    typedef union packed {
        logic signed [`NKMD_IMM_W-1:0] imm_view;
        inst_reg_view_t                reg_view;
    } inst_low_u;

    typedef struct packed {
        logic [3:0]                unused;
        logic [`NKMD_REGSEL_W-1:0] rd_sel;
        logic [`NKMD_ALUSEL_W-1:0] alu_op;
        logic [`NKMD_REGSEL_W-1:0] rs_sel;
        logic                      imm_en;
        inst_low_u                 low;
    } inst_t;

    typedef struct packed {
        logic [`NKMD_REGSEL_W-1:0] rd_sel;
        logic [`NKMD_REGSEL_W-1:0] rs_sel;
        logic [`NKMD_REGSEL_W-1:0] rt_sel;
        logic [`NKMD_ALUSEL_W-1:0] alu_op;
        logic [`NKMD_WORD_W-1:0]   imm;
        logic                      imm_en;
        logic                      r_read_en;
        logic                      c_read_en;
        logic                      repn;
    } dcd_t;

    // Operation after register read
    typedef struct packed {
        logic [`NKMD_REGSEL_W-1:0] rd_sel;
        logic [`NKMD_ALUSEL_W-1:0] alu_op;
        logic [`NKMD_WORD_W-1:0]   imm;
        logic                      imm_en;
        logic                      r_read_en;
        logic                      c_read_en;
        logic [`NKMD_WORD_W-1:0]   rs_val;
        logic [`NKMD_WORD_W-1:0]   rt_val;
    } exec_t;

    typedef struct packed {
        logic [`NKMD_REGSEL_W-1:0] sel;
        logic [`NKMD_WORD_W-1:0]   val;
    } wb_t;

endpackage

// File: verilog/nkmd_regfile.sv
`timescale 1ns/1ps
`include "nkmd_config.svh"

module nkmd_regfile (
    input  logic            clk,
    input  logic            rst,
    input  nkmd_pkg::dcd_t  dcd_i,
    input  logic            dec_n_i,
    input  nkmd_pkg::wb_t   wb_i,
    output nkmd_pkg::exec_t exec_o,
    output logic            n_is_zero_o
);
    import nkmd_pkg::*;

    localparam int NUM_SLOTS = 2 ** `NKMD_REGSEL_W;

    logic [`NKMD_WORD_W-1:0] gpr_q [NUM_SLOTS];
    logic [`NKMD_WORD_W-1:0] n_q;
    logic                    n_zero_q;
    logic                    wb_to_n;
    exec_t                   exec_q;

    // a..j, sl and sh
    function automatic logic is_gpr(input logic [`NKMD_REGSEL_W-1:0] sel);
        return !(sel inside {`NKMD_REG_C0, `NKMD_REG_RA, `NKMD_REG_N, `NKMD_REG_PC});
    endfunction

    function automatic logic [`NKMD_WORD_W-1:0] read_reg(
        input logic [`NKMD_REGSEL_W-1:0] sel
    );
        logic [`NKMD_WORD_W-1:0] val;
        if (sel == `NKMD_REG_N) begin
            val = n_q;
        end else if (is_gpr(sel)) begin
            val = gpr_q[sel];
        end else begin
            val = '0;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                gpr_q[i] <= '0;
            end
        end else if (is_gpr(wb_i.sel)) begin
            gpr_q[wb_i.sel] <= wb_i.val;
        end
    end

    assign wb_to_n = (wb_i.sel == `NKMD_REG_N);

    // Writeback takes priority over the repeat decrement
    always_ff @(posedge clk) begin
        if (rst) begin
            n_q      <= '0;
            n_zero_q <= 1'b1;
        end else if (wb_to_n) begin
            n_q      <= wb_i.val;
            n_zero_q <= (wb_i.val == '0);
        end else if (dec_n_i) begin
            n_q      <= n_q - 1'b1;
            n_zero_q <= (n_q == `NKMD_WORD_W'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_q <= '0;
        end else begin
            exec_q.rd_sel    <= dcd_i.rd_sel;
            exec_q.alu_op    <= dcd_i.alu_op;
            exec_q.imm       <= dcd_i.imm;
            exec_q.imm_en    <= dcd_i.imm_en;
            exec_q.r_read_en <= dcd_i.r_read_en;
            exec_q.c_read_en <= dcd_i.c_read_en;
            exec_q.rs_val    <= read_reg(dcd_i.rs_sel);
            exec_q.rt_val    <= read_reg(dcd_i.rt_sel);
        end
    end

    assign exec_o      = exec_q;
    assign n_is_zero_o = n_zero_q;

    // Zero flag tracks the value of n
    a_n_zero: assert property (@(posedge clk) disable iff (rst) n_zero_q == (n_q == '0))
        else $error("regfile: n zero flag disagrees with n");

endmodule

// File: verilog/nkmd_seq.sv
`timescale 1ns/1ps

module nkmd_seq (
    input  logic clk,
    input  logic rst,
    input  logic repn_i,
    input  logic n_is_zero_i,
    output logic stall_o,
    output logic dec_n_o,
    output logic use_hold_o,
    output logic inst_valid_o
);

    logic repeat_more;
    logic use_hold_q;
    logic inst_valid_q;

    // Another issue of the instruction in decode
    assign repeat_more = repn_i && !n_is_zero_i;

    assign stall_o = repeat_more;
    assign dec_n_o = repeat_more;

    // Program bus has one cycle of latency after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= 1'b1;
        end
    end

    // High in the cycle after a stall cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            use_hold_q <= 1'b0;
        end else begin
            use_hold_q <= repeat_more;
        end
    end

    assign use_hold_o   = use_hold_q;
    assign inst_valid_o = inst_valid_q;

    // Decode holds the repeat instruction across a stall
    a_stall_repn: assert property (@(posedge clk) disable iff (rst) stall_o |=> repn_i)
        else $error("seq: repeat instruction left decode during a stall");

endmodule
